// File: common/mrp_cfg.svh
`ifndef MRP_CFG_SVH
`define MRP_CFG_SVH

// physical address and stream beat widths
`define MRP_ADDR_W 32
`define MRP_DATA_W 64

// beats carried by a cache block read
`define MRP_BLOCK_BEATS 4

// depth of the response beat buffer and the pending write buffer
`define MRP_BUF_ELS 2

// speculation table entries, indexed just above the block offset
`define MRP_SPEC_SETS 8

// byte offset bits inside a 32 byte block
`define MRP_BLOCK_OFFSET 5

// addresses at or above this base are not cacheable
`define MRP_UC_BASE 32'h8000_0000

`endif

// File: common/mrp_pkg.sv
`default_nettype none

package mrp_pkg;

  `include "mrp_cfg.svh"

  typedef logic [`MRP_ADDR_W-1:0] addr_t;
  typedef logic [`MRP_DATA_W-1:0] data_t;
  typedef logic [1:0]             lce_id_t;
  typedef logic [2:0]             way_id_t;
  // code 0 is one byte, a block read uses code 5
  typedef logic [2:0]             size_t;

  typedef enum logic [2:0] {
    e_coh_invalid,
    e_coh_shared,
    e_coh_exclusive,
    e_coh_modified,
    e_coh_owned,
    e_coh_forward
  } coh_state_e;

  typedef enum logic [2:0] {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr,
    e_mem_amo
  } mem_msg_e;

  typedef enum logic [1:0] {
    e_cmd_data,
    e_cmd_uc_data,
    e_cmd_uc_st_done
  } cmd_msg_e;

  typedef enum logic {
    e_cce_mode_normal,
    e_cce_mode_uncached
  } cce_mode_e;

  typedef struct packed {
    mem_msg_e   msg_type;
    addr_t      addr;
    size_t      size;
    lce_id_t    lce_id;
    way_id_t    way_id;
    coh_state_e state;
    logic       speculative;
    logic       uncached;
  } mem_resp_hdr_t;

  // every beat repeats the header of its message
  typedef struct packed {
    mem_resp_hdr_t hdr;
    data_t         data;
    logic          last;
  } mem_beat_t;

  typedef struct packed {
    cmd_msg_e   msg_type;
    addr_t      addr;
    size_t      size;
    lce_id_t    dst_id;
    way_id_t    way_id;
    coh_state_e state;
  } lce_cmd_hdr_t;

  typedef struct packed {
    logic       spec;
    logic       squash;
    logic       fwd_mod;
    coh_state_e state;
  } spec_t;

  typedef struct packed {
    addr_t addr;
    logic  spec_en;
    logic  squash_en;
    logic  fwd_mod_en;
    logic  state_en;
    spec_t bits;
  } spec_wr_t;

  typedef struct packed {
    addr_t addr;
    logic  up;
    logic  down;
    logic  clear;
  } pending_req_t;

endpackage

`default_nettype wire

// File: hdl/beat_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "mrp_cfg.svh"

module beat_fifo
  import mrp_pkg::*;
  #(parameter int width_p = $bits(mem_beat_t),
    parameter int els_p   = `MRP_BUF_ELS
  ) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               v_i,
  input  wire logic [width_p-1:0] data_i,
  output logic                    ready_o,
  output logic                    v_o,
  output logic [width_p-1:0]      data_o,
  input  wire logic               yumi_i
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                push;
  logic                pop;

  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_r + ptr_w_lp'(1);
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_r + ptr_w_lp'(1);
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_r <= count_r + cnt_w_lp'(1);
      end else if (pop && !push) begin
        count_r <= count_r - cnt_w_lp'(1);
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("beat_fifo popped while empty");

endmodule

`default_nettype wire

// File: hdl/mem_resp_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "mrp_cfg.svh"

module mem_resp_pipe
  import mrp_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         reset_i,
  input  wire cce_mode_e    cce_mode_i,

  // spec table write port
  input  wire logic         spec_w_v_i,
  input  wire spec_wr_t     spec_w_i,

  // memory response stream
  input  wire mem_beat_t    mem_resp_i,
  input  wire logic         mem_resp_v_i,
  output logic              mem_resp_ready_o,

  // LCE command
  output lce_cmd_hdr_t      lce_cmd_hdr_o,
  output logic              lce_cmd_hdr_v_o,
  input  wire logic         lce_cmd_hdr_ready_i,
  output logic              lce_cmd_has_data_o,
  output data_t             lce_cmd_data_o,
  output logic              lce_cmd_data_v_o,
  input  wire logic         lce_cmd_data_ready_i,
  output logic              lce_cmd_last_o,

  // pending bit writes
  output pending_req_t      pending_w_o,
  output logic              pending_w_v_o,
  input  wire logic         pending_w_yumi_i,

  output logic              mem_credit_return_o
);

  mem_beat_t    head_beat;
  logic         head_v;
  logic         head_yumi;
  spec_t        head_spec;
  pending_req_t pend_req;
  logic         pend_v;
  logic         pend_ready;

  // input beats wait here for the forwarding FSM
  beat_fifo #(
    .width_p ($bits(mem_beat_t)),
    .els_p   (`MRP_BUF_ELS)
  ) resp_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (mem_resp_v_i),
    .data_i  (mem_resp_i),
    .ready_o (mem_resp_ready_o),
    .v_o     (head_v),
    .data_o  (head_beat),
    .yumi_i  (head_yumi)
  );

  spec_table i_spec_table (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .w_v_i    (spec_w_v_i),
    .w_i      (spec_w_i),
    .r_addr_i (head_beat.hdr.addr),
    .spec_o   (head_spec)
  );

  resp_fwd_ctrl i_resp_fwd_ctrl (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .cce_mode_i           (cce_mode_i),
    .beat_i               (head_beat),
    .beat_v_i             (head_v),
    .beat_yumi_o          (head_yumi),
    .credit_o             (mem_credit_return_o),
    .spec_i               (head_spec),
    .lce_cmd_hdr_o        (lce_cmd_hdr_o),
    .lce_cmd_hdr_v_o      (lce_cmd_hdr_v_o),
    .lce_cmd_hdr_ready_i  (lce_cmd_hdr_ready_i),
    .lce_cmd_has_data_o   (lce_cmd_has_data_o),
    .lce_cmd_data_o       (lce_cmd_data_o),
    .lce_cmd_data_v_o     (lce_cmd_data_v_o),
    .lce_cmd_data_ready_i (lce_cmd_data_ready_i),
    .lce_cmd_last_o       (lce_cmd_last_o),
    .pend_o               (pend_req),
    .pend_v_o             (pend_v),
    .pend_ready_i         (pend_ready)
  );

  // pending decrements queue up for the directory
  beat_fifo #(
    .width_p ($bits(pending_req_t)),
    .els_p   (`MRP_BUF_ELS)
  ) pend_buf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (pend_v),
    .data_i  (pend_req),
    .ready_o (pend_ready),
    .v_o     (pending_w_v_o),
    .data_o  (pending_w_o),
    .yumi_i  (pending_w_yumi_i)
  );

endmodule

`default_nettype wire

// File: hdl/spec_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "mrp_cfg.svh"

module spec_table
  import mrp_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,

  // write port from the coherent pipe
  input  wire logic     w_v_i,
  input  wire spec_wr_t w_i,

  // read port, looked up with the head beat address
  input  wire addr_t    r_addr_i,
  output spec_t         spec_o
);

  localparam int idx_w_lp = $clog2(`MRP_SPEC_SETS);

  spec_t               table_r [`MRP_SPEC_SETS];
  logic [idx_w_lp-1:0] w_idx;
  logic [idx_w_lp-1:0] r_idx;

  // index with the bits just above the block offset
  assign w_idx = w_i.addr[`MRP_BLOCK_OFFSET +: idx_w_lp];
  assign r_idx = r_addr_i[`MRP_BLOCK_OFFSET +: idx_w_lp];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MRP_SPEC_SETS; i++) begin
        table_r[i] <= '0;
      end
    end else if (w_v_i) begin
      // only enabled fields change
      if (w_i.spec_en) begin
        table_r[w_idx].spec <= w_i.bits.spec;
      end
      if (w_i.squash_en) begin
        table_r[w_idx].squash <= w_i.bits.squash;
      end
      if (w_i.fwd_mod_en) begin
        table_r[w_idx].fwd_mod <= w_i.bits.fwd_mod;
      end
      if (w_i.state_en) begin
        table_r[w_idx].state <= w_i.bits.state;
      end
    end
  end

  // combinational read, a write shows up after the edge
  assign spec_o = table_r[r_idx];

endmodule

`default_nettype wire

// File: resp_fwd/resp_fwd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mrp_cfg.svh"

module resp_fwd_ctrl
  import mrp_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire cce_mode_e cce_mode_i,

  // head of the response beat buffer
  input  wire mem_beat_t beat_i,
  input  wire logic      beat_v_i,
  output logic           beat_yumi_o,
  output logic           credit_o,

  // speculation bits for the head beat address
  input  wire spec_t     spec_i,

  // LCE command
  output lce_cmd_hdr_t   lce_cmd_hdr_o,
  output logic           lce_cmd_hdr_v_o,
  input  wire logic      lce_cmd_hdr_ready_i,
  output logic           lce_cmd_has_data_o,
  output data_t          lce_cmd_data_o,
  output logic           lce_cmd_data_v_o,
  input  wire logic      lce_cmd_data_ready_i,
  output logic           lce_cmd_last_o,

  // pending write buffer
  output pending_req_t   pend_o,
  output logic           pend_v_o,
  input  wire logic      pend_ready_i
);

  typedef enum logic [1:0] {
    e_ready,
    e_send_data,
    e_drain
  } state_e;

  state_e        state_r;
  state_e        state_n;
  mem_resp_hdr_t hdr;
  logic          normal_mode;
  logic          cacheable;
  logic          last_ok;
  logic          beat_valid;

  assign hdr = beat_i.hdr;

  // cacheable only below the uncached base in normal mode
  assign normal_mode = (cce_mode_i == e_cce_mode_normal);
  assign cacheable   = normal_mode & (hdr.addr < addr_t'(`MRP_UC_BASE));

  // a cacheable last beat needs room for its pending write
  assign last_ok    = ~beat_i.last | ~cacheable | pend_ready_i;
  assign beat_valid = beat_v_i & last_ok;

  always_comb begin
    state_n     = state_r;
    beat_yumi_o = 1'b0;

    lce_cmd_hdr_o.msg_type = e_cmd_data;
    lce_cmd_hdr_o.addr     = hdr.addr;
    lce_cmd_hdr_o.size     = hdr.size;
    lce_cmd_hdr_o.dst_id   = hdr.lce_id;
    lce_cmd_hdr_o.way_id   = hdr.way_id;
    lce_cmd_hdr_o.state    = hdr.state;
    lce_cmd_hdr_v_o        = 1'b0;
    lce_cmd_has_data_o     = 1'b0;
    lce_cmd_data_v_o       = 1'b0;

    unique case (state_r)
      e_ready: begin
        unique case (hdr.msg_type)
          e_mem_rd: begin
            if (hdr.speculative && spec_i.spec) begin
              // hold the head beat until speculation resolves
            end else if (hdr.speculative && spec_i.squash) begin
              beat_yumi_o = beat_valid;
              if (beat_yumi_o && !beat_i.last) begin
                state_n = e_drain;
              end
            end else begin
              lce_cmd_hdr_v_o    = beat_valid;
              lce_cmd_has_data_o = 1'b1;
              if (hdr.speculative && spec_i.fwd_mod) begin
                lce_cmd_hdr_o.state = spec_i.state;
              end
              // first beat stays at the head until data goes out
              if (lce_cmd_hdr_v_o && lce_cmd_hdr_ready_i) begin
                state_n = e_send_data;
              end
            end
          end
          e_mem_wr: begin
            beat_yumi_o = beat_valid;
          end
          e_mem_uc_rd: begin
            lce_cmd_hdr_v_o        = beat_valid;
            lce_cmd_has_data_o     = 1'b1;
            lce_cmd_hdr_o.msg_type = hdr.uncached ? e_cmd_uc_data : e_cmd_data;
            if (lce_cmd_hdr_v_o && lce_cmd_hdr_ready_i) begin
              state_n = e_send_data;
            end
          end
          e_mem_uc_wr: begin
            // header only and the beat leaves with it
            lce_cmd_hdr_v_o        = beat_valid;
            lce_cmd_hdr_o.msg_type = e_cmd_uc_st_done;
            lce_cmd_hdr_o.size     = '0;
            beat_yumi_o            = beat_valid & lce_cmd_hdr_ready_i;
          end
          default: begin
            // atomics are never consumed
          end
        endcase
      end
      e_send_data: begin
        lce_cmd_data_v_o = beat_valid;
        beat_yumi_o      = beat_valid & lce_cmd_data_ready_i;
        if (beat_yumi_o && beat_i.last) begin
          state_n = e_ready;
        end
      end
      e_drain: begin
        // squashed read data goes nowhere
        beat_yumi_o = beat_valid;
        if (beat_yumi_o && beat_i.last) begin
          state_n = e_ready;
        end
      end
      default: begin
        state_n = e_ready;
      end
    endcase
  end

  assign lce_cmd_data_o = beat_i.data;
  assign lce_cmd_last_o = beat_i.last;

  // memory responses only ever decrement the pending count
  assign pend_o   = '{addr: hdr.addr, up: 1'b0, down: 1'b1, clear: 1'b0};
  assign pend_v_o = beat_yumi_o & beat_i.last & cacheable;
  assign credit_o = beat_yumi_o & beat_i.last;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  a_spec_only_on_read: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_v_i && hdr.speculative |-> hdr.msg_type == e_mem_rd)
    else $error("speculative response on a non-read message");

  a_no_spec_uncached: assert property (@(posedge clk_i) disable iff (reset_i)
    beat_v_i && hdr.speculative |-> normal_mode)
    else $error("speculative response in uncached mode");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the memory response pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f tb.f --top-module tb_mem_resp_pipe -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed!$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// File: tb.f
+incdir+common
common/mrp_pkg.sv
hdl/beat_fifo.sv
hdl/spec_table.sv
resp_fwd/resp_fwd_ctrl.sv
hdl/mem_resp_pipe.sv
tb/tb_mem_resp_pipe.sv

// File: tb/tb_mem_resp_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "mrp_cfg.svh"

module tb_mem_resp_pipe
  import mrp_pkg::*;
();

  localparam int num_rand_lp = 40;
  // 21 directed beats plus every random message counted as a full read
  localparam int beat_total_lp  = 21 + `MRP_BLOCK_BEATS * num_rand_lp;
  localparam int cycle_limit_lp = 40 * beat_total_lp;

  typedef struct packed {
    logic         has_cmd;
    lce_cmd_hdr_t cmd;
    logic         has_data;
    logic         has_pend;
    pending_req_t pend;
    logic [2:0]   beats;
  } expect_t;

  logic         clk_i;
  logic         reset_i;
  cce_mode_e    cce_mode_i;
  logic         spec_w_v_i;
  spec_wr_t     spec_w_i;
  mem_beat_t    mem_resp_i;
  logic         mem_resp_v_i;
  logic         mem_resp_ready_o;
  lce_cmd_hdr_t lce_cmd_hdr_o;
  logic         lce_cmd_hdr_v_o;
  logic         lce_cmd_hdr_ready_i;
  logic         lce_cmd_has_data_o;
  data_t        lce_cmd_data_o;
  logic         lce_cmd_data_v_o;
  logic         lce_cmd_data_ready_i;
  logic         lce_cmd_last_o;
  pending_req_t pending_w_o;
  logic         pending_w_v_o;
  logic         pending_w_yumi_i;
  logic         mem_credit_return_o;

  integer       seed = 32'h1c997dcb;
  logic [31:0]  rnd_bp;
  logic         bp_en;
  logic         hold_hdr;
  int           msg_cnt;
  int           credit_cnt;
  int           cycle_cnt;

  lce_cmd_hdr_t exp_hdr_q[$];
  logic         exp_has_data_q[$];
  data_t        exp_data_q[$];
  logic         exp_last_q[$];
  pending_req_t exp_pend_q[$];

  mem_resp_pipe i_mem_resp_pipe (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .cce_mode_i           (cce_mode_i),
    .spec_w_v_i           (spec_w_v_i),
    .spec_w_i             (spec_w_i),
    .mem_resp_i           (mem_resp_i),
    .mem_resp_v_i         (mem_resp_v_i),
    .mem_resp_ready_o     (mem_resp_ready_o),
    .lce_cmd_hdr_o        (lce_cmd_hdr_o),
    .lce_cmd_hdr_v_o      (lce_cmd_hdr_v_o),
    .lce_cmd_hdr_ready_i  (lce_cmd_hdr_ready_i),
    .lce_cmd_has_data_o   (lce_cmd_has_data_o),
    .lce_cmd_data_o       (lce_cmd_data_o),
    .lce_cmd_data_v_o     (lce_cmd_data_v_o),
    .lce_cmd_data_ready_i (lce_cmd_data_ready_i),
    .lce_cmd_last_o       (lce_cmd_last_o),
    .pending_w_o          (pending_w_o),
    .pending_w_v_o        (pending_w_v_o),
    .pending_w_yumi_i     (pending_w_yumi_i),
    .mem_credit_return_o  (mem_credit_return_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "run stopped at the first failing check");
  endtask

  task automatic check_hdr(input lce_cmd_hdr_t got, input lce_cmd_hdr_t exp);
    if (got !== exp) begin
      $display("Error at %0t: lce_cmd_hdr_o is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Error at %0t: lce_cmd_data_o is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pend(input pending_req_t got, input pending_req_t exp);
    if (got !== exp) begin
      $display("Error at %0t: pending_w_o is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // expected LCE command, pending request and beat count of one response
  function automatic expect_t predict_resp(input mem_resp_hdr_t hdr, input cce_mode_e mode,
                                           input spec_t res);
    expect_t e;
    e = '0;
    e.cmd.msg_type = e_cmd_data;
    e.cmd.addr     = hdr.addr;
    e.cmd.size     = hdr.size;
    e.cmd.dst_id   = hdr.lce_id;
    e.cmd.way_id   = hdr.way_id;
    e.cmd.state    = hdr.state;
    e.beats        = 3'd1;
    case (hdr.msg_type)
      e_mem_rd: begin
        e.beats = 3'(`MRP_BLOCK_BEATS);
        // a squashed read is drained without a command
        if (!(hdr.speculative && res.squash)) begin
          e.has_cmd  = 1'b1;
          e.has_data = 1'b1;
          if (hdr.speculative && res.fwd_mod) begin
            e.cmd.state = res.state;
          end
        end
      end
      e_mem_uc_rd: begin
        e.has_cmd      = 1'b1;
        e.has_data     = 1'b1;
        e.cmd.msg_type = hdr.uncached ? e_cmd_uc_data : e_cmd_data;
      end
      e_mem_uc_wr: begin
        e.has_cmd      = 1'b1;
        e.cmd.msg_type = e_cmd_uc_st_done;
        e.cmd.size     = 3'd0;
      end
      default: begin
        // writeback ack sends nothing to the LCE
      end
    endcase
    e.has_pend = (mode == e_cce_mode_normal) && (hdr.addr < `MRP_UC_BASE);
    e.pend     = '{addr: hdr.addr, up: 1'b0, down: 1'b1, clear: 1'b0};
    return e;
  endfunction

  function automatic mem_resp_hdr_t make_hdr(input mem_msg_e msg, input addr_t addr,
                                             input size_t size, input coh_state_e st,
                                             input logic uc);
    mem_resp_hdr_t h;
    h = '{msg_type: msg, addr: addr, size: size, lce_id: 2'd1, way_id: 3'd3,
          state: st, speculative: 1'b0, uncached: uc};
    return h;
  endfunction

  // input ready is looked at mid cycle where it is stable
  task automatic send_beat(input mem_beat_t beat);
    mem_resp_i   = beat;
    mem_resp_v_i = 1'b1;
    @(negedge clk_i);
    while (!mem_resp_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    mem_resp_v_i = 1'b0;
  endtask

  task automatic send_msg(input mem_resp_hdr_t hdr, input spec_t res);
    expect_t     e;
    mem_beat_t   beat;
    logic [31:0] r0;
    logic [31:0] r1;
    e = predict_resp(hdr, cce_mode_i, res);
    msg_cnt++;
    if (e.has_cmd) begin
      exp_hdr_q.push_back(e.cmd);
      exp_has_data_q.push_back(e.has_data);
    end
    if (e.has_pend) begin
      exp_pend_q.push_back(e.pend);
    end
    for (int i = 0; i < int'(e.beats); i++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      beat.hdr  = hdr;
      beat.data = {r0, r1};
      beat.last = (i == int'(e.beats) - 1);
      if (e.has_data) begin
        exp_data_q.push_back(beat.data);
        exp_last_q.push_back(beat.last);
      end
      send_beat(beat);
    end
  endtask

  task automatic write_spec(input addr_t wr_addr, input spec_t bits);
    spec_w_i   = '{addr: wr_addr, spec_en: 1'b1, squash_en: 1'b1, fwd_mod_en: 1'b1,
                   state_en: 1'b1, bits: bits};
    spec_w_v_i = 1'b1;
    @(posedge clk_i);
    #1;
    spec_w_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while (exp_hdr_q.size() != 0 || exp_data_q.size() != 0 ||
           exp_pend_q.size() != 0 || credit_cnt != msg_cnt) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  // read held by an unresolved spec bit until res is written
  task automatic spec_read(input addr_t addr, input coh_state_e st, input spec_t res);
    mem_resp_hdr_t hdr;
    hdr = make_hdr(e_mem_rd, addr, 3'd5, st, 1'b0);
    hdr.speculative = 1'b1;
    write_spec(addr, '{spec: 1'b1, squash: 1'b0, fwd_mod: 1'b0, state: e_coh_invalid});
    hold_hdr = 1'b1;
    fork
      send_msg(hdr, res);
      begin
        // long enough for the beat buffer to fill behind the held read
        repeat (10) @(posedge clk_i);
        #1;
        hold_hdr = 1'b0;
        write_spec(addr, res);
      end
    join
    wait_idle();
  endtask

  task automatic random_mix();
    logic [31:0]   rnd;
    mem_resp_hdr_t hdr;
    mem_msg_e      msg;
    for (int n = 0; n < num_rand_lp; n++) begin
      rnd = $random(seed);
      msg = mem_msg_e'({1'b0, rnd[1:0]});
      hdr = make_hdr(msg, {rnd[31], 18'h0, rnd[15:3]},
                     (msg == e_mem_rd) ? 3'd5 : rnd[18:16],
                     coh_state_e'(rnd[21:19] % 3'd6), rnd[22]);
      hdr.lce_id = rnd[24:23];
      hdr.way_id = rnd[27:25];
      send_msg(hdr, '0);
    end
    wait_idle();
  endtask

  // output ready and pending pops go random under back-pressure
  always @(posedge clk_i) begin
    #1;
    if (bp_en) begin
      rnd_bp = $random(seed);
      lce_cmd_hdr_ready_i  = rnd_bp[0] | rnd_bp[1];
      lce_cmd_data_ready_i = rnd_bp[2] | rnd_bp[3];
      pending_w_yumi_i     = pending_w_v_o & rnd_bp[4] & !reset_i;
    end else begin
      lce_cmd_hdr_ready_i  = 1'b1;
      lce_cmd_data_ready_i = 1'b1;
      pending_w_yumi_i     = pending_w_v_o & !reset_i;
    end
  end

  // monitor samples mid cycle before the handshake edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit_lp) begin
        $display("timeout after %0d cycles with results still outstanding", cycle_cnt);
        stop_run();
      end
      if (lce_cmd_hdr_v_o && hold_hdr) begin
        $display("LCE command header offered while speculation was unresolved");
        stop_run();
      end
      if (lce_cmd_hdr_v_o && lce_cmd_hdr_ready_i) begin
        if (exp_hdr_q.size() == 0) begin
          $display("LCE command header sent when none was expected");
          stop_run();
        end else begin
          check_hdr(lce_cmd_hdr_o, exp_hdr_q.pop_front());
          check_bit("lce_cmd_has_data_o", lce_cmd_has_data_o, exp_has_data_q.pop_front());
        end
      end
      if (lce_cmd_data_v_o && lce_cmd_data_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("LCE command data beat sent when none was expected");
          stop_run();
        end else begin
          check_data(lce_cmd_data_o, exp_data_q.pop_front());
          check_bit("lce_cmd_last_o", lce_cmd_last_o, exp_last_q.pop_front());
        end
      end
      if (pending_w_v_o && pending_w_yumi_i) begin
        if (exp_pend_q.size() == 0) begin
          $display("pending request issued when none was expected");
          stop_run();
        end else begin
          check_pend(pending_w_o, exp_pend_q.pop_front());
        end
      end
      if (mem_credit_return_o) begin
        if (credit_cnt >= msg_cnt) begin
          $display("memory credit returned with no message outstanding");
          stop_run();
        end else begin
          credit_cnt++;
        end
      end
    end
  end

  initial begin
    clk_i                = 1'b0;
    reset_i              = 1'b1;
    cce_mode_i           = e_cce_mode_normal;
    spec_w_v_i           = 1'b0;
    spec_w_i             = '0;
    mem_resp_i           = '0;
    mem_resp_v_i         = 1'b0;
    lce_cmd_hdr_ready_i  = 1'b0;
    lce_cmd_data_ready_i = 1'b0;
    pending_w_yumi_i     = 1'b0;
    bp_en                = 1'b0;
    hold_hdr             = 1'b0;
    msg_cnt              = 0;
    credit_cnt           = 0;
    cycle_cnt            = 0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // cached read with four forwarded beats
    send_msg(make_hdr(e_mem_rd, 32'h0000_1020, 3'd5, e_coh_exclusive, 1'b0), '0);
    wait_idle();

    // uncached reads with and without the flag and an uncached store
    send_msg(make_hdr(e_mem_uc_rd, 32'h8000_0100, 3'd3, e_coh_invalid, 1'b1), '0);
    send_msg(make_hdr(e_mem_uc_rd, 32'h9000_0008, 3'd3, e_coh_invalid, 1'b0), '0);
    send_msg(make_hdr(e_mem_uc_wr, 32'ha000_0010, 3'd2, e_coh_invalid, 1'b1), '0);
    wait_idle();

    // writeback acks in both modes
    send_msg(make_hdr(e_mem_wr, 32'h0000_2000, 3'd5, e_coh_invalid, 1'b0), '0);
    wait_idle();
    cce_mode_i = e_cce_mode_uncached;
    send_msg(make_hdr(e_mem_wr, 32'h0000_2040, 3'd5, e_coh_invalid, 1'b0), '0);
    wait_idle();
    cce_mode_i = e_cce_mode_normal;

    // squash, forward as modified, plain forward
    spec_read(32'h0000_3060, e_coh_shared,
              '{spec: 1'b0, squash: 1'b1, fwd_mod: 1'b0, state: e_coh_invalid});
    spec_read(32'h0000_4080, e_coh_shared,
              '{spec: 1'b0, squash: 1'b0, fwd_mod: 1'b1, state: e_coh_modified});
    spec_read(32'h0000_50a0, e_coh_exclusive,
              '{spec: 1'b0, squash: 1'b0, fwd_mod: 1'b0, state: e_coh_owned});

    bp_en = 1'b1;
    random_mix();

    if (credit_cnt == msg_cnt && exp_hdr_q.size() == 0 && exp_data_q.size() == 0 &&
        exp_pend_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d credits returned for %0d messages, or results still outstanding",
               credit_cnt, msg_cnt);
      stop_run();
    end
  end

endmodule

`default_nettype wire
